// File: hdl/mcu_consts.svh
/*
	Shared constants of the microcontroller
	Data, instruction and address widths, flash depth, register count
	Programming sync bytes, output port I/O addresses, idle timeout
*/
`ifndef MCU_CONSTS_SVH
`define MCU_CONSTS_SVH

`define MCU_DATA_WIDTH 8
`define MCU_PC_WIDTH 10
`define MCU_FLASH_DEPTH 1024
`define MCU_INSTR_WIDTH 16
`define MCU_REG_COUNT 32

// Sequence that switches the loader into programming mode
`define MCU_SYNC_BYTE0 8'hA9
`define MCU_SYNC_BYTE1 8'h44
`define MCU_SYNC_BYTE2 8'h45

`define MCU_IO_PORTB 6'h05
`define MCU_IO_PORTD 6'h0B

`define MCU_DEFAULT_IDLE_CYCLES 5000000

`endif

// File: hdl/mcuPkg.sv
/*
	Types shared by the microcontroller modules
	Vector typedefs for bytes, words, addresses and register numbers
	Core sequencer states and decoded opcodes
*/
`default_nettype none

`include "mcu_consts.svh"

package mcuPkg;

	typedef logic [`MCU_DATA_WIDTH-1:0] dataByte;
	typedef logic [`MCU_INSTR_WIDTH-1:0] instrWord;
	typedef logic [`MCU_PC_WIDTH-1:0] progAddr;
	typedef logic [$clog2(`MCU_REG_COUNT)-1:0] regAddr;
	typedef logic [5:0] ioAddr;            // AVR I/O space for in and out

	// Six steps per instruction, stuck on an unknown word
	typedef enum logic [2:0] {
		fetchRequest,
		fetchLatch,
		decode,
		execute1,
		execute2,
		execute3,
		stuck
	} coreState;

	typedef enum logic [3:0] {
		opLdi,
		opOut,
		opRjmp,
		opBreq,
		opBrne,
		opSubi,
		opCpi,
		opAdd,
		opEor,
		opAndi,
		opOri,
		opMov,
		opNop,
		opIllegal
	} opcode;

endpackage

`default_nettype wire

// File: hdl/programWriteBus.sv
/*
	Flash write path from the program loader
	Carries the programming level to the core as well
*/
`timescale 1ns/100ps
`default_nettype none

interface programWriteBus;

	logic programming;                     // High while a new program is loaded
	logic wordWrite;
	mcuPkg::progAddr wordAddress;
	mcuPkg::instrWord wordData;

	modport loader (output programming, output wordWrite, output wordAddress,
		output wordData);

	modport flash (input wordWrite, input wordAddress, input wordData);

	// Core only needs to know when to hold itself
	modport core (input programming);

endinterface

`default_nettype wire

// File: hdl/serialLoader.sv
/*
	Serial program loader
	Detects the sync sequence in the received byte stream
	Pairs following bytes into little-endian instruction words for the flash
	Leaves programming mode after a run of idle cycles
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module serialLoader
#(
	parameter int unsigned idleCycles = `MCU_DEFAULT_IDLE_CYCLES
)
(
	input wire logic finalClock,
	input wire logic reset,
	input wire mcuPkg::dataByte rxByte,
	input wire logic rxToggle,
	programWriteBus.loader writeBus
);

	localparam int idleWidth = $clog2(idleCycles + 1);

	logic toggleCopy;
	logic newByte;
	logic [1:0] syncMatch;                 // Number of sync bytes seen so far
	logic [1:0] restartMatch;
	logic [`MCU_PC_WIDTH:0] byteCount;
	logic [idleWidth-1:0] idleCount;
	mcuPkg::dataByte lowByte;

	assign newByte = (rxToggle != toggleCopy);

	// A wrong byte may still be the start of a new sequence
	assign restartMatch = (rxByte == `MCU_SYNC_BYTE0) ? 2'd1 : 2'd0;

	always_ff @(posedge finalClock)
	begin
		toggleCopy <= rxToggle;
		if (reset)
		begin
			writeBus.programming <= 1'b0;
			writeBus.wordWrite <= 1'b0;
			syncMatch <= '0;
			byteCount <= '0;
			idleCount <= '0;
		end
		else if (!writeBus.programming)
		begin
			writeBus.wordWrite <= 1'b0;
			if (newByte)
			begin
				case (syncMatch)
					2'd0: syncMatch <= restartMatch;
					2'd1: syncMatch <= (rxByte == `MCU_SYNC_BYTE1) ? 2'd2 : restartMatch;
					default:
					begin
						if (rxByte == `MCU_SYNC_BYTE2)
						begin
							writeBus.programming <= 1'b1;
							byteCount <= '0;
							idleCount <= idleWidth'(idleCycles);
							syncMatch <= '0;
						end
						else
						begin
							syncMatch <= restartMatch;
						end
					end
				endcase
			end
		end
		else if (newByte)
		begin
			writeBus.wordWrite <= byteCount[0];    // Second byte of a pair
			byteCount <= byteCount + 1'b1;
			idleCount <= idleWidth'(idleCycles);
		end
		else
		begin
			writeBus.wordWrite <= 1'b0;
			idleCount <= idleCount - 1'b1;
			if (idleCount <= 1)
			begin
				writeBus.programming <= 1'b0;
			end
		end
	end

	// Word assembly, low byte arrives first
	always_ff @(posedge finalClock)
	begin
		if (writeBus.programming && newByte)
		begin
			if (!byteCount[0])
			begin
				lowByte <= rxByte;
			end
			else
			begin
				writeBus.wordData <= {rxByte, lowByte};
				writeBus.wordAddress <= byteCount[`MCU_PC_WIDTH:1];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/programFlash.sv
/*
	Program memory
	Synchronous write from the loader bus
	Registered read port for instruction fetch
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module programFlash
(
	input wire logic finalClock,
	programWriteBus.flash writeBus,
	input wire mcuPkg::progAddr fetchAddress,
	output mcuPkg::instrWord fetchWord
);

	mcuPkg::instrWord memory [`MCU_FLASH_DEPTH];

	always_ff @(posedge finalClock)
	begin
		if (writeBus.wordWrite)
		begin
			memory[writeBus.wordAddress] <= writeBus.wordData;
		end
		fetchWord <= memory[fetchAddress];     // Word is valid one cycle after the address
	end

endmodule

`default_nettype wire

// File: hdl/instructionDecoder.sv
/*
	Instruction decoder for the supported AVR subset
	Maps an instruction word to an opcode
	Extracts register numbers, immediate, I/O address and branch offset
*/
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder
(
	input wire mcuPkg::instrWord instruction,
	output mcuPkg::opcode op,
	output mcuPkg::regAddr destReg,
	output mcuPkg::regAddr srcReg,
	output mcuPkg::dataByte immediate,
	output mcuPkg::ioAddr ioAddress,
	output mcuPkg::progAddr branchOffset
);

	logic immediateForm;

	always_comb
	begin
		op = mcuPkg::opIllegal;
		casez (instruction)
			16'b0000_0000_0000_0000: op = mcuPkg::opNop;
			16'b1110_????_????_????: op = mcuPkg::opLdi;
			16'b1011_1???_????_????: op = mcuPkg::opOut;
			16'b1100_????_????_????: op = mcuPkg::opRjmp;
			16'b1111_00??_????_?001: op = mcuPkg::opBreq;
			16'b1111_01??_????_?001: op = mcuPkg::opBrne;
			16'b0101_????_????_????: op = mcuPkg::opSubi;
			16'b0011_????_????_????: op = mcuPkg::opCpi;
			16'b0000_11??_????_????: op = mcuPkg::opAdd;
			16'b0010_01??_????_????: op = mcuPkg::opEor;
			16'b0111_????_????_????: op = mcuPkg::opAndi;
			16'b0110_????_????_????: op = mcuPkg::opOri;
			16'b0010_11??_????_????: op = mcuPkg::opMov;
			default: op = mcuPkg::opIllegal;
		endcase
	end

	// Immediate forms only reach r16 to r31
	assign immediateForm = (op == mcuPkg::opLdi) || (op == mcuPkg::opSubi) ||
		(op == mcuPkg::opCpi) || (op == mcuPkg::opAndi) || (op == mcuPkg::opOri);

	assign destReg = immediateForm ? {1'b1, instruction[7:4]} : instruction[8:4];

	// out names its source in the field other ops use for the destination
	assign srcReg = (op == mcuPkg::opOut) ? instruction[8:4] :
		{instruction[9], instruction[3:0]};

	assign immediate = {instruction[11:8], instruction[3:0]};
	assign ioAddress = {instruction[10:9], instruction[3:0]};

	// 12-bit relative jump or 7-bit conditional branch, both signed
	assign branchOffset = (op == mcuPkg::opRjmp) ?
		mcuPkg::progAddr'($signed(instruction[11:0])) :
		mcuPkg::progAddr'($signed(instruction[9:3]));

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
/*
	General purpose registers r0 to r31
	Two combinational read ports, one synchronous write port
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module registerFile
(
	input wire logic finalClock,
	input wire mcuPkg::regAddr readAddressA,
	output mcuPkg::dataByte readDataA,
	input wire mcuPkg::regAddr readAddressB,
	output mcuPkg::dataByte readDataB,
	input wire logic writeEnable,
	input wire mcuPkg::regAddr writeAddress,
	input wire mcuPkg::dataByte writeData
);

	mcuPkg::dataByte registers [`MCU_REG_COUNT];

	assign readDataA = registers[readAddressA];
	assign readDataB = registers[readAddressB];

	always_ff @(posedge finalClock)
	begin
		if (writeEnable)
		begin
			registers[writeAddress] <= writeData;
		end
	end

endmodule

`default_nettype wire

// File: hdl/avrCore.sv
/*
	Executing core
	Six-step fetch, decode and execute sequencer with program counter
	ALU for the supported subset, carry, zero and negative flags
	Output ports at I/O addresses 0x05 and 0x0B
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module avrCore
(
	input wire logic finalClock,
	input wire logic reset,
	programWriteBus.core progBus,
	output mcuPkg::progAddr fetchAddress,
	input wire mcuPkg::instrWord fetchWord,
	output mcuPkg::progAddr pc,
	output logic stuck,
	output mcuPkg::dataByte portB,
	output mcuPkg::dataByte portD
);

	mcuPkg::coreState state;
	mcuPkg::instrWord instruction;

	// Decoder outputs and their copies held for the execute steps
	mcuPkg::opcode decodedOp;
	mcuPkg::regAddr decodedDest;
	mcuPkg::regAddr decodedSrc;
	mcuPkg::dataByte decodedImmediate;
	mcuPkg::ioAddr decodedIo;
	mcuPkg::progAddr decodedOffset;
	mcuPkg::opcode opLatched;
	mcuPkg::regAddr destLatched;
	mcuPkg::regAddr srcLatched;
	mcuPkg::dataByte immLatched;
	mcuPkg::ioAddr ioLatched;
	mcuPkg::progAddr offsetLatched;

	mcuPkg::dataByte readDataA;
	mcuPkg::dataByte readDataB;
	mcuPkg::dataByte operandA;
	mcuPkg::dataByte operandB;

	logic [`MCU_DATA_WIDTH:0] difference;
	logic [`MCU_DATA_WIDTH:0] sum;
	mcuPkg::dataByte aluResult;
	logic carryNext;
	logic writesRegister;
	logic updatesFlags;
	logic carryFlag;
	logic zeroFlag;
	logic negativeFlag;
	logic branchTaken;

	instructionDecoder decoder_inst (
		.instruction(instruction),
		.op(decodedOp),
		.destReg(decodedDest),
		.srcReg(decodedSrc),
		.immediate(decodedImmediate),
		.ioAddress(decodedIo),
		.branchOffset(decodedOffset)
	);

	registerFile registerFile_inst (
		.finalClock(finalClock),
		.readAddressA(destLatched),
		.readDataA(readDataA),
		.readAddressB(srcLatched),
		.readDataB(readDataB),
		.writeEnable(writesRegister && (state == mcuPkg::execute2)),
		.writeAddress(destLatched),
		.writeData(aluResult)
	);

	assign fetchAddress = pc;
	assign stuck = (state == mcuPkg::stuck);

	// Borrow and carry come out in the extra top bit
	assign difference = {1'b0, operandA} - {1'b0, immLatched};
	assign sum = {1'b0, operandA} + {1'b0, operandB};

	always_comb
	begin
		aluResult = immLatched;
		carryNext = carryFlag;             // Logic ops keep the carry
		writesRegister = 1'b0;
		updatesFlags = 1'b0;
		case (opLatched)
			mcuPkg::opLdi: writesRegister = 1'b1;
			mcuPkg::opSubi, mcuPkg::opCpi:
			begin
				aluResult = difference[`MCU_DATA_WIDTH-1:0];
				carryNext = difference[`MCU_DATA_WIDTH];
				writesRegister = (opLatched == mcuPkg::opSubi);
				updatesFlags = 1'b1;
			end
			mcuPkg::opAdd:
			begin
				aluResult = sum[`MCU_DATA_WIDTH-1:0];
				carryNext = sum[`MCU_DATA_WIDTH];
				writesRegister = 1'b1;
				updatesFlags = 1'b1;
			end
			mcuPkg::opEor, mcuPkg::opAndi, mcuPkg::opOri:
			begin
				if (opLatched == mcuPkg::opEor)
					aluResult = operandA ^ operandB;
				else if (opLatched == mcuPkg::opAndi)
					aluResult = operandA & immLatched;
				else
					aluResult = operandA | immLatched;
				writesRegister = 1'b1;
				updatesFlags = 1'b1;
			end
			mcuPkg::opMov:
			begin
				aluResult = operandB;
				writesRegister = 1'b1;
			end
			default: aluResult = immLatched;
		endcase
	end

	always_comb
	begin
		case (opLatched)
			mcuPkg::opRjmp: branchTaken = 1'b1;
			mcuPkg::opBreq: branchTaken = zeroFlag;
			mcuPkg::opBrne: branchTaken = !zeroFlag;
			default: branchTaken = 1'b0;
		endcase
	end

	always_ff @(posedge finalClock)
	begin
		if (reset || progBus.programming)
		begin
			state <= mcuPkg::fetchRequest;
			pc <= '0;
			carryFlag <= 1'b0;
			zeroFlag <= 1'b0;
			negativeFlag <= 1'b0;
			portB <= '0;
			portD <= '0;
		end
		else
		begin
			case (state)
				mcuPkg::fetchRequest: state <= mcuPkg::fetchLatch;
				mcuPkg::fetchLatch: state <= mcuPkg::decode;
				mcuPkg::decode:
				begin
					state <= (decodedOp == mcuPkg::opIllegal) ? mcuPkg::stuck : mcuPkg::execute1;
				end
				mcuPkg::execute1: state <= mcuPkg::execute2;
				mcuPkg::execute2:
				begin
					if (updatesFlags)
					begin
						carryFlag <= carryNext;
						zeroFlag <= (aluResult == '0);
						negativeFlag <= aluResult[`MCU_DATA_WIDTH-1];
					end
					if (opLatched == mcuPkg::opOut)
					begin
						if (ioLatched == `MCU_IO_PORTB)
							portB <= operandB;
						else if (ioLatched == `MCU_IO_PORTD)
							portD <= operandB;
					end
					state <= mcuPkg::execute3;
				end
				mcuPkg::execute3:
				begin
					pc <= branchTaken ? pc + offsetLatched + 1'b1 : pc + 1'b1;
					state <= mcuPkg::fetchRequest;
				end
				default: state <= mcuPkg::stuck;   // Left only by a new program
			endcase
		end
	end

	// Instruction word, decoded fields and operands
	always_ff @(posedge finalClock)
	begin
		if (state == mcuPkg::fetchLatch)
		begin
			instruction <= fetchWord;
		end
		if (state == mcuPkg::decode)
		begin
			opLatched <= decodedOp;
			destLatched <= decodedDest;
			srcLatched <= decodedSrc;
			immLatched <= decodedImmediate;
			ioLatched <= decodedIo;
			offsetLatched <= decodedOffset;
		end
		if (state == mcuPkg::execute1)
		begin
			operandA <= readDataA;
			operandB <= readDataB;
		end
	end

endmodule

`default_nettype wire

// File: hdl/basicMcu.sv
/*
	Microcontroller top level
	Serial loader, program flash and core joined by the flash write bus
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module basicMcu
#(
	parameter int unsigned idleCycles = `MCU_DEFAULT_IDLE_CYCLES
)
(
	input wire logic finalClock,
	input wire logic reset,
	input wire mcuPkg::dataByte rxByte,
	input wire logic rxToggle,
	output logic programming,
	output logic stuck,
	output mcuPkg::progAddr pc,
	output mcuPkg::dataByte portB,
	output mcuPkg::dataByte portD
);

	mcuPkg::progAddr fetchAddress;
	mcuPkg::instrWord fetchWord;

	programWriteBus writeBus ();

	assign programming = writeBus.programming;

	serialLoader #(
		.idleCycles(idleCycles)
	) serialLoader_inst (
		.finalClock(finalClock),
		.reset(reset),
		.rxByte(rxByte),
		.rxToggle(rxToggle),
		.writeBus(writeBus.loader)
	);

	programFlash programFlash_inst (
		.finalClock(finalClock),
		.writeBus(writeBus.flash),
		.fetchAddress(fetchAddress),
		.fetchWord(fetchWord)
	);

	avrCore avrCore_inst (
		.finalClock(finalClock),
		.reset(reset),
		.progBus(writeBus.core),
		.fetchAddress(fetchAddress),
		.fetchWord(fetchWord),
		.pc(pc),
		.stuck(stuck),
		.portB(portB),
		.portD(portD)
	);

endmodule

`default_nettype wire

// File: testbench/basicMcu_asserts.sv
/*
	Protocol assertions bound to the microcontroller top level
	Core held at zero while a program loads
	Program counter frozen while stuck
	Programming raised only right after a received byte
*/
`timescale 1ns/100ps
`default_nettype none

module basicMcu_asserts
(
	input wire logic finalClock,
	input wire logic reset,
	input wire logic rxToggle,
	input wire logic programming,
	input wire logic stuck,
	input wire mcuPkg::progAddr pc,
	input wire mcuPkg::dataByte portB,
	input wire mcuPkg::dataByte portD
);

	int failCount = 0;                     // Number of failed assertions

	heldWhileLoading: assert property (@(posedge finalClock) disable iff (reset)
		programming |=> (pc == '0 && portB == '0 && portD == '0))
	else
	begin
		$error("Core not held at zero while programming");
		failCount++;
	end

	// Stuck is left only through a new program, which also moves the state
	frozenWhenStuck: assert property (@(posedge finalClock) disable iff (reset)
		(stuck && $past(stuck)) |-> $stable(pc))
	else
	begin
		$error("Program counter moved while the core was stuck");
		failCount++;
	end

	loadStartsOnByte: assert property (@(posedge finalClock) disable iff (reset)
		$rose(programming) |-> ($past(rxToggle) != $past(rxToggle, 2)))
	else
	begin
		$error("Programming rose without a byte toggle in the cycle before");
		failCount++;
	end

endmodule

bind basicMcu basicMcu_asserts basicMcu_asserts_inst (
	.finalClock(finalClock),
	.reset(reset),
	.rxToggle(rxToggle),
	.programming(programming),
	.stuck(stuck),
	.pc(pc),
	.portB(portB),
	.portD(portD)
);

`default_nettype wire

// File: testbench/basicMcuTb.sv
/*
	Testbench for the microcontroller
	Clock, reset, serial byte stimulus and program image loading
	Instruction encoders for the supported subset
	Tests for reset, sync and idle, output ports, ALU, loops and stuck recovery
	Cycle limit and closing summary
*/
`timescale 1ns/100ps
`default_nettype none

`include "mcu_consts.svh"

module basicMcuTb;

	localparam int idleTime = 200;
	localparam int sentBytes = 90;         // Sync sequences plus program bytes
	localparam int loadCount = 6;
	localparam int executedInstructions = 100;
	localparam int cycleLimit =
		2 * (8 + 4 * sentBytes + idleTime * loadCount + 6 * executedInstructions);

	logic finalClock;
	logic reset;
	logic [7:0] rxByte;
	logic rxToggle;
	logic programming;
	logic stuck;
	logic [9:0] pc;
	logic [7:0] portB;
	logic [7:0] portD;

	logic [15:0] image [$];                // Program words, address 0 first
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;

	basicMcu #(
		.idleCycles(idleTime)
	) basicMcu_inst (
		.finalClock(finalClock),
		.reset(reset),
		.rxByte(rxByte),
		.rxToggle(rxToggle),
		.programming(programming),
		.stuck(stuck),
		.pc(pc),
		.portB(portB),
		.portD(portD)
	);

	always #50 finalClock = !finalClock;

	always @(posedge finalClock)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: no result after %0d cycles", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ldi, subi, cpi, andi, ori on r16 to r31
	function automatic logic [15:0] encodeImmediate(input logic [3:0] prefix, input int rd,
		input logic [7:0] k);
		logic [3:0] d;
		d = 4'(rd - 16);
		return {prefix, k[7:4], d, k[3:0]};
	endfunction

	function automatic logic [15:0] encodeRegisterPair(input logic [5:0] prefix, input int rd,
		input int rr);
		logic [4:0] d;
		logic [4:0] r;
		d = 5'(rd);
		r = 5'(rr);
		return {prefix, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] encodeOut(input logic [5:0] address, input int rr);
		logic [4:0] r;
		r = 5'(rr);
		return {5'b10111, address[5:4], r, address[3:0]};
	endfunction

	function automatic logic [15:0] encodeRjmp(input int offset);
		return {4'hC, 12'(offset)};
	endfunction

	function automatic logic [15:0] encodeBranch(input logic ifNotEqual, input int offset);
		return {4'hF, 1'b0, ifNotEqual, 7'(offset), 3'b001};
	endfunction

	task automatic sendByte(input logic [7:0] value);
		@(posedge finalClock);
		rxByte <= value;
		rxToggle <= !rxToggle;
		repeat (3) @(posedge finalClock);  // One byte every 4 cycles
	endtask

	task automatic sendSync();
		sendByte(`MCU_SYNC_BYTE0);
		sendByte(`MCU_SYNC_BYTE1);
		sendByte(`MCU_SYNC_BYTE2);
	endtask

	task automatic loadProgram();
		sendSync();
		foreach (image[i])
		begin
			sendByte(image[i][7:0]);           // Little endian
			sendByte(image[i][15:8]);
		end
		@(negedge finalClock);
		while (programming)
			@(negedge finalClock);
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(negedge finalClock);
	endtask

	task automatic waitForPc(input logic [9:0] address);
		while (pc !== address)
			@(negedge finalClock);
	endtask

	task automatic checkValue(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Mismatch in %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string testName, input int errorsAtStart);
		testsRun++;
		if (errorCount == errorsAtStart)
		begin
			$display("Test %s passed", testName);
		end
		else
		begin
			testsFailed++;
			$display("Test %s failed with %0d errors", testName, errorCount - errorsAtStart);
		end
	endtask

	task automatic testReset();
		int errorsAtStart;
		errorsAtStart = errorCount;
		checkValue("reset", 0, programming);
		checkValue("reset", 0, stuck);
		checkValue("reset", 0, portB);
		checkValue("reset", 0, portD);
		checkValue("reset", 0, pc);
		finishTest("reset", errorsAtStart);
	endtask

	task automatic testSyncAndIdle();
		int errorsAtStart;
		logic [7:0] value;
		errorsAtStart = errorCount;
		repeat (6)
		begin
			value = 8'($urandom);
			if (value == `MCU_SYNC_BYTE0)
				value = value ^ 8'h01;         // No sequence may start here
			sendByte(value);
			@(negedge finalClock);
			checkValue("syncIdle", 0, programming);
		end
		sendSync();
		@(negedge finalClock);
		checkValue("syncIdle", 1, programming);
		waitCycles(idleTime - 20);
		checkValue("syncIdle", 1, programming);
		waitCycles(30);
		checkValue("syncIdle", 0, programming);
		finishTest("syncIdle", errorsAtStart);
	endtask

	task automatic testPortOutput();
		int errorsAtStart;
		logic [7:0] value;
		errorsAtStart = errorCount;
		value = 8'($urandom);
		image.delete();
		image.push_back(encodeImmediate(4'hE, 16, value));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeOut(`MCU_IO_PORTD, 16));
		image.push_back(encodeRjmp(-1));
		loadProgram();
		waitForPc(3);
		checkValue("portOutput", value, portB);
		checkValue("portOutput", value, portD);
		finishTest("portOutput", errorsAtStart);
	endtask

	task automatic testAlu();
		int errorsAtStart;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] andMask;
		logic [7:0] orMask;
		logic [7:0] expected [5];
		errorsAtStart = errorCount;
		a = 8'($urandom);
		b = 8'($urandom);
		andMask = 8'($urandom);
		orMask = 8'($urandom);
		expected[0] = a + b;                   // Sum wraps at 8 bits
		expected[1] = expected[0] ^ b;
		expected[2] = expected[1] & andMask;
		expected[3] = expected[2] | orMask;
		expected[4] = b;
		image.delete();
		image.push_back(encodeImmediate(4'hE, 16, a));
		image.push_back(encodeImmediate(4'hE, 17, b));
		image.push_back(encodeRegisterPair(6'b000011, 16, 17));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeRegisterPair(6'b001001, 16, 17));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeImmediate(4'h7, 16, andMask));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeImmediate(4'h6, 16, orMask));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeRegisterPair(6'b001011, 18, 17));
		image.push_back(encodeOut(`MCU_IO_PORTB, 18));
		image.push_back(encodeRjmp(-1));
		loadProgram();
		// Each out sits at an odd address, the result shows once pc moves past it
		for (int i = 0; i < 5; i++)
		begin
			waitForPc(10'(4 + 2 * i));
			checkValue("alu", expected[i], portB);
		end
		finishTest("alu", errorsAtStart);
	endtask

	task automatic testCountdown();
		int errorsAtStart;
		int remaining;
		logic [7:0] count;
		errorsAtStart = errorCount;
		count = 8'(1 + $urandom % 20);
		image.delete();
		image.push_back(encodeImmediate(4'hE, 16, count));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));     // Loop start
		image.push_back(encodeImmediate(4'h5, 16, 8'd1));
		image.push_back(encodeBranch(1'b1, -3));
		image.push_back(encodeImmediate(4'h3, 16, 8'd0));
		image.push_back(encodeBranch(1'b0, 1));
		image.push_back(encodeRjmp(-1));                   // Reached only on a wrong flag
		image.push_back(encodeImmediate(4'hE, 17, 8'h5A));
		image.push_back(encodeOut(`MCU_IO_PORTD, 17));
		image.push_back(encodeRjmp(-1));
		loadProgram();
		remaining = count;
		while (remaining >= 1)
		begin
			waitForPc(2);
			checkValue("countdown", remaining, portB);
			checkValue("countdown", 0, portD);
			while (pc == 2)
				@(negedge finalClock);
			remaining--;
		end
		waitForPc(9);
		checkValue("countdown", 8'h5A, portD);
		checkValue("countdown", 1, portB);
		finishTest("countdown", errorsAtStart);
	endtask

	task automatic testStuckRecovery();
		int errorsAtStart;
		logic [7:0] firstValue;
		logic [7:0] secondValue;
		errorsAtStart = errorCount;
		firstValue = 8'($urandom);
		secondValue = 8'($urandom);
		image.delete();
		image.push_back(encodeImmediate(4'hE, 16, firstValue));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(16'hFFFF);
		loadProgram();
		while (!stuck)
			@(negedge finalClock);
		checkValue("stuckRecovery", 2, pc);
		checkValue("stuckRecovery", firstValue, portB);
		waitCycles(12);
		checkValue("stuckRecovery", 1, stuck);
		checkValue("stuckRecovery", 2, pc);
		image.delete();
		image.push_back(encodeImmediate(4'hE, 16, secondValue));
		image.push_back(encodeOut(`MCU_IO_PORTB, 16));
		image.push_back(encodeRjmp(-1));
		loadProgram();
		checkValue("stuckRecovery", 0, stuck);
		waitForPc(2);
		checkValue("stuckRecovery", secondValue, portB);
		checkValue("stuckRecovery", 0, stuck);
		finishTest("stuckRecovery", errorsAtStart);
	endtask

	initial
	begin
		void'($urandom(32'h8358));
		finalClock = 1'b0;
		reset = 1'b1;
		rxByte = '0;
		rxToggle = 1'b0;
		repeat (8) @(posedge finalClock);
		reset <= 1'b0;
		@(negedge finalClock);
		testReset();
		testSyncAndIdle();
		testPortOutput();
		testAlu();
		testCountdown();
		testStuckRecovery();
		errorCount += basicMcu_inst.basicMcu_asserts_inst.failCount;
		$display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
			errorCount);
		if (errorCount == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/mcuPkg.sv
hdl/programWriteBus.sv
hdl/serialLoader.sv
hdl/programFlash.sv
hdl/instructionDecoder.sv
hdl/registerFile.sv
hdl/avrCore.sv
hdl/basicMcu.sv
testbench/basicMcu_asserts.sv
testbench/basicMcuTb.sv
